/* console_bus.f */
src/bus_pkg.sv
src/periph_pkg.sv
src/axil_front.sv
src/scratch_ram.sv
src/timebase.sv
src/pad_reader.sv
src/console_bus_top.sv
tests/console_bus_sva.sv
tests/tb_console_bus.sv

/* run_sim.sh */
#!/bin/sh
# Build the console_bus testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_console_bus -f console_bus.f; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_console_bus)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1

/* tests/tb_console_bus.sv */
// Testbench for console_bus_top: random AXI4-Lite traffic and gamepad models checked against a model
`timescale 1ns/100ps

module tb_console_bus;
	import bus_pkg::*;
	import periph_pkg::*;

	localparam int CLK_NS = 20;
	localparam int RAM_WORDS = 64;
	localparam int PAD_DIV = 4;
	localparam int SCAN_CYCLES = 18 * PAD_DIV;
	localparam int TEST_WORDS = 8;
	localparam int TXN_CYCLES = 16;
	localparam int WATCHDOG_NS = (60 * TXN_CYCLES + 4 * SCAN_CYCLES + 64) * CLK_NS;

	logic clk_50mhz;
	logic resetn;
	addr_t awaddr;
	addr_t araddr;
	data_t wdata;
	data_t rdata;
	strb_t wstrb;
	resp_t bresp;
	resp_t rresp;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	logic pad0_data, pad1_data, pad0_latch, pad0_clock, pad1_latch, pad1_clock;

	pad_buttons_t pad0_buttons = '0;
	pad_buttons_t pad1_buttons = '0;
	int pad0_bit = 0;
	int pad1_bit = 0;
	data_t ram_model [0:TEST_WORDS-1];
	logic [31:0] rng_state = 32'd16216;
	int cycle = 0;
	int checks = 0;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	console_bus_top #(
		.RAM_WORDS(RAM_WORDS),
		.PAD_TICK_DIV(PAD_DIV)
	) i_dut (.*);

	initial begin
		clk_50mhz = 1'b0;
		forever #(CLK_NS / 2) clk_50mhz = ~clk_50mhz;
	end

	always @(posedge clk_50mhz)
		cycle <= cycle + 1;

	// Pad model: reload on latch, next bit on each rising pad clock, pressed reads low
	always @(posedge pad0_latch)
		pad0_bit <= 0;
	always @(posedge pad0_clock)
		pad0_bit <= pad0_bit + 1;
	always @(posedge pad1_latch)
		pad1_bit <= 0;
	always @(posedge pad1_clock)
		pad1_bit <= pad1_bit + 1;
	assign pad0_data = (pad0_bit < PAD_BITS) ? ~pad0_buttons[pad0_bit] : 1'b0;
	assign pad1_data = (pad1_bit < PAD_BITS) ? ~pad1_buttons[pad1_bit] : 1'b0;

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired: the tests did not complete within %0d ns", WATCHDOG_NS);
		$display("** FAIL **");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("[ERROR] %0t ns: %s", $time, what);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("Test %0d, %s: passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d, %s: failed with %0d errors", tests_run, name,
				errors - errors_before);
		end
	endtask

	task automatic write_word(input addr_t addr, input data_t data, input strb_t strb,
			output resp_t resp);
		int delay;
		awaddr <= addr;
		wdata <= data;
		wstrb <= strb;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do begin
			@(posedge clk_50mhz);
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(posedge clk_50mhz);
		check(bvalid, "write response missing one cycle after acceptance");
		resp = bresp;
		delay = next_rand() % 4;
		// Response must hold while bready stays low
		repeat (delay) begin
			@(posedge clk_50mhz);
			check(bvalid && bresp == resp && !awready && !wready && !arready,
				$sformatf("write response changed under back-pressure at %h", addr));
		end
		bready <= 1'b1;
		@(posedge clk_50mhz);
		bready <= 1'b0;
	endtask

	task automatic read_word(input addr_t addr, output data_t data, output resp_t resp,
			output int accepted);
		int delay;
		araddr <= addr;
		arvalid <= 1'b1;
		do begin
			@(posedge clk_50mhz);
		end while (!arready);
		accepted = cycle;
		arvalid <= 1'b0;
		repeat (2) @(posedge clk_50mhz);
		check(rvalid, "read response missing two cycles after acceptance");
		data = rdata;
		resp = rresp;
		delay = next_rand() % 4;
		repeat (delay) begin
			@(posedge clk_50mhz);
			check(rvalid && rdata == data && rresp == resp && !awready && !arready,
				$sformatf("read response changed under back-pressure at %h", addr));
		end
		rready <= 1'b1;
		@(posedge clk_50mhz);
		rready <= 1'b0;
	endtask

	initial begin
		data_t got;
		data_t word;
		data_t prev_count;
		resp_t resp;
		strb_t strb;
		addr_t addr;
		int idx;
		int acc;
		int prev_acc;
		int start;
		int next_idx;

		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		awvalid = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arvalid = 1'b0;
		rready = 1'b0;
		resetn = 1'b0;
		repeat (2) @(posedge clk_50mhz);
		resetn <= 1'b1;

		start = errors;
		for (int i = 0; i < TEST_WORDS; i++) begin
			ram_model[i] = next_rand();
			write_word(RAM_BASE + 4 * i, ram_model[i], 4'hf, resp);
			check(resp == RESP_OKAY, $sformatf("RAM write %0d answered %0d", i, resp));
		end
		repeat (12) begin
			idx = next_rand() % TEST_WORDS;
			word = next_rand();
			strb = strb_t'(next_rand());
			write_word(RAM_BASE + 4 * idx, word, strb, resp);
			check(resp == RESP_OKAY, $sformatf("RAM write %0d answered %0d", idx, resp));
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					ram_model[idx][8*b +: 8] = word[8*b +: 8];
				end
			end
		end
		for (int i = 0; i < TEST_WORDS; i++) begin
			read_word(RAM_BASE + 4 * i, got, resp, acc);
			check(got == ram_model[i] && resp == RESP_OKAY,
				$sformatf("RAM word %0d read %h resp %0d, expected %h", i, got, resp,
					ram_model[i]));
		end
		report_test("RAM byte-strobe writes and reads", start);

		start = errors;
		read_word(COUNTER_ADDR, prev_count, resp, prev_acc);
		repeat (4) begin
			repeat (next_rand() % 8) @(posedge clk_50mhz);
			read_word(COUNTER_ADDR, got, resp, acc);
			check(got >= prev_count + data_t'(acc - prev_acc) && resp == RESP_OKAY,
				$sformatf("counter read %h after %h over %0d cycles", got, prev_count,
					acc - prev_acc));
			prev_count = got;
			prev_acc = acc;
		end
		report_test("system counter reads", start);

		start = errors;
		repeat (2) begin
			pad0_buttons <= pad_buttons_t'(next_rand());
			pad1_buttons <= pad_buttons_t'(next_rand());
			repeat (2 * SCAN_CYCLES) @(posedge clk_50mhz);
			read_word(PAD_ADDR, got, resp, acc);
			check(got == {16'h0000, pad1_buttons, pad0_buttons} && resp == RESP_OKAY,
				$sformatf("pad read %h, expected %h", got,
					{16'h0000, pad1_buttons, pad0_buttons}));
		end
		report_test("gamepad scan", start);

		start = errors;
		// RAM ends at 0x100 with 64 words
		addr = 32'h0000_0100 + ((next_rand() % 64) << 2);
		write_word(addr, next_rand(), 4'hf, resp);
		check(resp == RESP_DECERR, $sformatf("unmapped write %h answered %0d", addr, resp));
		read_word(addr, got, resp, acc);
		check(got == '0 && resp == RESP_DECERR,
			$sformatf("unmapped read %h gave %h resp %0d", addr, got, resp));
		read_word(32'h0000_1008, got, resp, acc);
		check(got == '0 && resp == RESP_DECERR,
			$sformatf("unmapped read 1008 gave %h resp %0d", got, resp));
		read_word(COUNTER_ADDR, prev_count, resp, prev_acc);
		write_word(COUNTER_ADDR, 32'h0, 4'hf, resp);
		check(resp == RESP_SLVERR, $sformatf("counter write answered %0d", resp));
		read_word(COUNTER_ADDR, got, resp, acc);
		check(got >= prev_count + data_t'(acc - prev_acc) && resp == RESP_OKAY,
			$sformatf("counter read %h after write, before it %h", got, prev_count));
		write_word(PAD_ADDR, 32'hffff_ffff, 4'hf, resp);
		check(resp == RESP_SLVERR, $sformatf("pad write answered %0d", resp));
		read_word(PAD_ADDR, got, resp, acc);
		check(got == {16'h0000, pad1_buttons, pad0_buttons},
			$sformatf("pad read %h after write", got));
		report_test("decode and write errors", start);

		start = errors;
		idx = next_rand() % TEST_WORDS;
		word = next_rand();
		for (int i = 0; i < 3; i++) begin
			// Read request waits behind the write response
			araddr <= RAM_BASE + 4 * idx;
			arvalid <= 1'b1;
			write_word(RAM_BASE + 4 * idx, word, 4'hf, resp);
			check(resp == RESP_OKAY, $sformatf("RAM write %0d answered %0d", idx, resp));
			ram_model[idx] = word;
			next_idx = next_rand() % TEST_WORDS;
			word = next_rand();
			fork
				read_word(RAM_BASE + 4 * idx, got, resp, acc);
				begin
					// Next write request waits behind the read response
					if (i < 2) begin
						do begin
							@(posedge clk_50mhz);
						end while (!(arvalid && arready));
						awaddr <= RAM_BASE + 4 * next_idx;
						wdata <= word;
						wstrb <= 4'hf;
						awvalid <= 1'b1;
						wvalid <= 1'b1;
					end
				end
			join
			check(got == ram_model[idx] && resp == RESP_OKAY,
				$sformatf("RAM word %0d read %h, expected %h", idx, got, ram_model[idx]));
			idx = next_idx;
		end
		report_test("response back-pressure", start);

		$display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d", tests_run,
			tests_failed, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* tests/console_bus_sva.sv */
// AXI4-Lite protocol assertions, bound to console_bus_top from this file
`timescale 1ns/100ps

module console_bus_sva (
	input logic           clk_50mhz,
	input logic           resetn,
	input logic           awvalid,
	input logic           awready,
	input logic           wvalid,
	input logic           wready,
	input logic           bvalid,
	input logic           bready,
	input bus_pkg::resp_t bresp,
	input logic           arvalid,
	input logic           arready,
	input logic           rvalid,
	input logic           rready,
	input bus_pkg::data_t rdata,
	input bus_pkg::resp_t rresp
);
	// Valids and payloads hold until their transfer
	a_aw_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		awvalid && !awready |=> awvalid) else $error("AW valid dropped before AW ready");
	a_w_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		wvalid && !wready |=> wvalid) else $error("W valid dropped before W ready");
	a_ar_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		arvalid && !arready |=> arvalid) else $error("AR valid dropped before AR ready");
	a_b_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		bvalid && !bready |=> bvalid && $stable(bresp)) else $error("B response not held");
	a_r_hold: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("R response not held");

	// Response latency
	a_r_after_ar: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$past(arvalid && arready, 2) |-> rvalid) else $error("R valid late after AR");
	a_r_only_after_ar: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$rose(rvalid) |-> $past(arvalid && arready, 2)) else $error("R valid without AR");
	a_b_after_aw: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		awvalid && awready |=> bvalid) else $error("B valid late after AW");
	a_b_only_after_aw: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		$rose(bvalid) |-> $past(awvalid && awready)) else $error("B valid without AW");

	a_no_ready: assert property (@(posedge clk_50mhz) disable iff (!resetn)
		bvalid || rvalid |-> !awready && !wready && !arready)
		else $error("ready raised while a response waits");

endmodule

bind console_bus_top console_bus_sva i_sva (.*);

/* src/console_bus_top.sv */
// Console peripheral bus top level: AXI4-Lite front end, scratch RAM, timebase and pad reader
`timescale 1ns/100ps

module console_bus_top #(
	parameter int RAM_WORDS    = 256,
	parameter int PAD_TICK_DIV = 512
) (
	input  logic           clk_50mhz,
	input  logic           resetn,

	input  bus_pkg::addr_t awaddr,
	input  logic           awvalid,
	output logic           awready,
	input  bus_pkg::data_t wdata,
	input  bus_pkg::strb_t wstrb,
	input  logic           wvalid,
	output logic           wready,
	output logic           bvalid,
	input  logic           bready,
	output bus_pkg::resp_t bresp,
	input  bus_pkg::addr_t araddr,
	input  logic           arvalid,
	output logic           arready,
	output logic           rvalid,
	input  logic           rready,
	output bus_pkg::data_t rdata,
	output bus_pkg::resp_t rresp,

	input  logic           pad0_data,
	input  logic           pad1_data,
	output logic           pad0_latch,
	output logic           pad0_clock,
	output logic           pad1_latch,
	output logic           pad1_clock
);
	import bus_pkg::*;
	import periph_pkg::*;

	logic [$clog2(RAM_WORDS)-1:0] ram_index;
	data_t ram_wdata;
	strb_t ram_we;
	logic ram_rd;
	data_t ram_rdata;

	count_t count;
	logic pad_tick;
	pad_buttons_t pad0_state;
	pad_buttons_t pad1_state;

	axil_front #(
		.RAM_WORDS(RAM_WORDS)
	) i_front (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.ram_index(ram_index),
		.ram_wdata(ram_wdata),
		.ram_we(ram_we),
		.ram_rd(ram_rd),
		.ram_rdata(ram_rdata),
		.count(count),
		.pad0_state(pad0_state),
		.pad1_state(pad1_state)
	);

	scratch_ram #(
		.RAM_WORDS(RAM_WORDS)
	) i_ram (
		.clk_50mhz(clk_50mhz),
		.index(ram_index),
		.wdata(ram_wdata),
		.we(ram_we),
		.rd(ram_rd),
		.rdata(ram_rdata)
	);

	timebase #(
		.PAD_TICK_DIV(PAD_TICK_DIV)
	) i_timebase (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.count(count),
		.pad_tick(pad_tick)
	);

	pad_reader i_pads (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.pad_tick(pad_tick),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data),
		.pad0_latch(pad0_latch),
		.pad0_clock(pad0_clock),
		.pad1_latch(pad1_latch),
		.pad1_clock(pad1_clock),
		.pad0_state(pad0_state),
		.pad1_state(pad1_state)
	);

endmodule

/* src/pad_reader.sv */
// Gamepad scanner: latches both pads, clocks out their bits on pad_tick and holds the result
`timescale 1ns/100ps

module pad_reader (
	input  logic                     clk_50mhz,
	input  logic                     resetn,
	input  logic                     pad_tick,

	input  logic                     pad0_data,
	input  logic                     pad1_data,
	output logic                     pad0_latch,
	output logic                     pad0_clock,
	output logic                     pad1_latch,
	output logic                     pad1_clock,

	output periph_pkg::pad_buttons_t pad0_state,
	output periph_pkg::pad_buttons_t pad1_state
);
	import periph_pkg::*;

	localparam int BIT_W = $clog2(PAD_BITS);

	typedef enum logic [1:0] {
		S_LATCH,
		S_UNLATCH,
		S_SAMPLE,
		S_RELEASE
	} state_t;

	state_t state;

	logic [BIT_W-1:0] bit_cnt;
	logic latch;
	logic clock;
	pad_buttons_t shift0;
	pad_buttons_t shift1;

	// Both pads share the same latch and clock timing
	assign pad0_latch = latch;
	assign pad1_latch = latch;
	assign pad0_clock = clock;
	assign pad1_clock = clock;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state      <= S_LATCH;
			bit_cnt    <= '0;
			latch      <= 1'b0;
			clock      <= 1'b0;
			pad0_state <= '0;
			pad1_state <= '0;
		end else if (pad_tick) begin
			case (state)
				S_LATCH: begin
					latch <= 1'b1;
					state <= S_UNLATCH;
				end
				S_UNLATCH: begin
					latch   <= 1'b0;
					bit_cnt <= '0;
					state   <= S_SAMPLE;
				end
				// Rising pad clock moves the pads on to their next bit
				S_SAMPLE: begin
					clock <= 1'b1;
					state <= S_RELEASE;
				end
				S_RELEASE: begin
					clock <= 1'b0;
					if (bit_cnt == BIT_W'(PAD_BITS - 1)) begin
						pad0_state <= shift0;
						pad1_state <= shift1;
						state      <= S_LATCH;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
						state   <= S_SAMPLE;
					end
				end
				default: begin
					state <= S_LATCH;
				end
			endcase
		end
	end

	// Pad data is active low, first bit ends up in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (pad_tick && state == S_SAMPLE) begin
			shift0 <= {~pad0_data, shift0[PAD_BITS-1:1]};
			shift1 <= {~pad1_data, shift1[PAD_BITS-1:1]};
		end
	end

endmodule

/* src/timebase.sv */
// System cycle counter and the divider that paces the gamepad scan
`timescale 1ns/100ps

module timebase #(
	parameter int PAD_TICK_DIV = 512
) (
	input  logic               clk_50mhz,
	input  logic               resetn,
	output periph_pkg::count_t count,
	output logic               pad_tick
);
	localparam int DIV_W = $clog2(PAD_TICK_DIV);

	logic [DIV_W-1:0] div_cnt;

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count    <= '0;
			div_cnt  <= '0;
			pad_tick <= 1'b0;
		end else begin
			count    <= count + 1'b1;
			pad_tick <= 1'b0;
			// One-cycle pulse every PAD_TICK_DIV clocks
			if (div_cnt == DIV_W'(PAD_TICK_DIV - 1)) begin
				div_cnt  <= '0;
				pad_tick <= 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

endmodule

/* src/scratch_ram.sv */
// Scratch RAM of RAM_WORDS bus words with byte-lane writes and a registered read port
`timescale 1ns/100ps

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  logic                         clk_50mhz,
	input  logic [$clog2(RAM_WORDS)-1:0] index,
	input  bus_pkg::data_t               wdata,
	input  bus_pkg::strb_t               we,
	input  logic                         rd,
	output bus_pkg::data_t               rdata
);
	import bus_pkg::*;

	localparam int LANES = $bits(strb_t);

	data_t mem [0:RAM_WORDS-1];

	// Each strobe bit enables one byte lane
	always_ff @(posedge clk_50mhz) begin
		for (int lane = 0; lane < LANES; lane++) begin
			if (we[lane]) begin
				mem[index][8*lane +: 8] <= wdata[8*lane +: 8];
			end
		end
	end

	// Read data valid the cycle after rd
	always_ff @(posedge clk_50mhz) begin
		if (rd) begin
			rdata <= mem[index];
		end
	end

endmodule

/* src/axil_front.sv */
// AXI4-Lite slave front end: handshakes, address decode, read mux and response codes
`timescale 1ns/100ps

module axil_front #(
	parameter int RAM_WORDS = 256
) (
	input  logic                           clk_50mhz,
	input  logic                           resetn,

	input  bus_pkg::addr_t                 awaddr,
	input  logic                           awvalid,
	output logic                           awready,
	input  bus_pkg::data_t                 wdata,
	input  bus_pkg::strb_t                 wstrb,
	input  logic                           wvalid,
	output logic                           wready,
	output logic                           bvalid,
	input  logic                           bready,
	output bus_pkg::resp_t                 bresp,
	input  bus_pkg::addr_t                 araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output logic                           rvalid,
	input  logic                           rready,
	output bus_pkg::data_t                 rdata,
	output bus_pkg::resp_t                 rresp,

	output logic [$clog2(RAM_WORDS)-1:0]   ram_index,
	output bus_pkg::data_t                 ram_wdata,
	output bus_pkg::strb_t                 ram_we,
	output logic                           ram_rd,
	input  bus_pkg::data_t                 ram_rdata,

	input  periph_pkg::count_t             count,
	input  periph_pkg::pad_buttons_t       pad0_state,
	input  periph_pkg::pad_buttons_t       pad1_state
);
	import bus_pkg::*;
	import periph_pkg::*;

	localparam int IDX_W = $clog2(RAM_WORDS);
	localparam addr_t RAM_BYTES = addr_t'(RAM_WORDS * 4);

	localparam logic [1:0] REGION_RAM     = 2'd0;
	localparam logic [1:0] REGION_COUNTER = 2'd1;
	localparam logic [1:0] REGION_PAD     = 2'd2;
	localparam logic [1:0] REGION_NONE    = 2'd3;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WRESP,
		S_RWAIT,
		S_RRESP
	} state_t;

	state_t state;

	logic write_accept;
	logic read_accept;
	addr_t sel_addr;
	addr_t sel_off;
	logic [1:0] sel_region;
	logic [1:0] rd_region;
	resp_t wr_resp;
	data_t pad_word;

	// Write wins over a read presented in the same cycle
	assign write_accept = (state == S_IDLE) && awvalid && wvalid;
	assign read_accept  = (state == S_IDLE) && arvalid && !(awvalid && wvalid);

	assign awready = write_accept;
	assign wready  = write_accept;
	assign arready = read_accept;

	assign bvalid = (state == S_WRESP);
	assign rvalid = (state == S_RRESP);

	// One decoder serves whichever channel is being accepted
	assign sel_addr = write_accept ? awaddr : araddr;
	assign sel_off  = sel_addr - RAM_BASE;

	always_comb begin
		if (sel_off < RAM_BYTES) begin
			sel_region = REGION_RAM;
		end else if (sel_addr[31:2] == COUNTER_ADDR[31:2]) begin
			sel_region = REGION_COUNTER;
		end else if (sel_addr[31:2] == PAD_ADDR[31:2]) begin
			sel_region = REGION_PAD;
		end else begin
			sel_region = REGION_NONE;
		end
	end

	// Read-only registers refuse writes with SLVERR
	always_comb begin
		case (sel_region)
			REGION_RAM:  wr_resp = RESP_OKAY;
			REGION_NONE: wr_resp = RESP_DECERR;
			default:     wr_resp = RESP_SLVERR;
		endcase
	end

	assign ram_index = sel_off[IDX_W+1:2];
	assign ram_wdata = wdata;
	assign ram_we    = (write_accept && sel_region == REGION_RAM) ? wstrb : '0;
	assign ram_rd    = read_accept && sel_region == REGION_RAM;

	always_comb begin
		pad_word = '0;
		pad_word[0 +: PAD_BITS] = pad0_state;
		pad_word[PAD_BITS +: PAD_BITS] = pad1_state;
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (write_accept) begin
						state <= S_WRESP;
					end else if (read_accept) begin
						state <= S_RWAIT;
					end
				end
				S_WRESP: begin
					if (bready) begin
						state <= S_IDLE;
					end
				end
				// RAM data arrives here, one cycle after the strobe
				S_RWAIT: begin
					state <= S_RRESP;
				end
				S_RRESP: begin
					if (rready) begin
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (write_accept) begin
			bresp <= wr_resp;
		end
		if (read_accept) begin
			rd_region <= sel_region;
		end
		if (state == S_RWAIT) begin
			case (rd_region)
				REGION_RAM:     rdata <= ram_rdata;
				REGION_COUNTER: rdata <= count;
				REGION_PAD:     rdata <= pad_word;
				default:        rdata <= '0;
			endcase
			rresp <= (rd_region == REGION_NONE) ? RESP_DECERR : RESP_OKAY;
		end
	end

endmodule

/* src/periph_pkg.sv */
// Types and constants of the counter and gamepad peripherals, imported where they are used
package periph_pkg;

	// Free-running cycle count
	typedef logic [31:0] count_t;

	// Buttons per pad, one per shifted bit
	localparam int PAD_BITS = 8;

	// Button state of one pad
	// 1 means pressed, bit 0 is the first bit out of the pad
	typedef logic [PAD_BITS-1:0] pad_buttons_t;

endpackage

/* src/bus_pkg.sv */
// Bus widths, response codes and address map for the AXI4-Lite path, imported by the bus blocks
package bus_pkg;

	// Byte address as seen on AW and AR
	typedef logic [31:0] addr_t;

	// One bus word on W and R
	typedef logic [31:0] data_t;

	// Byte lane enables, one per byte of data_t
	typedef logic [3:0] strb_t;

	// AXI response code on B and R
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	// Scratch RAM region starts here, its size comes from RAM_WORDS
	localparam addr_t RAM_BASE = 32'h0000_0000;

	// Read-only system count
	localparam addr_t COUNTER_ADDR = 32'h0000_1000;

	// Read-only gamepad state, pad 1 in the upper byte
	localparam addr_t PAD_ADDR = 32'h0000_1004;

endpackage
